// File: include/avg_config.svh
// moving-average filter configuration: sample width, largest window and APB address width
`ifndef AVG_CONFIG_SVH
`define AVG_CONFIG_SVH

// width of one sample and of one average
`define AVG_DATA_W 16

// log2 of the largest window, so the history is 1 << 4 = 16 deep
`define AVG_MAX_LOG2 4

// the register map fits in 4 address bits
`define AVG_ADDR_W 4

// the sum must hold a full window of maximum samples without overflow
// which gives AVG_DATA_W + AVG_MAX_LOG2 = 20 bits

`endif

// File: hdl/avg_pkg.sv
// moving-average filter package with the sample, window select and register offset types
`default_nettype none

`include "avg_config.svh"

package avg_pkg;

	// one sample or one average
	typedef logic [`AVG_DATA_W-1:0] sample_t;

	// window select as written by software, codes 5 to 7 act as 16
	typedef logic [2:0] win_sel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register offsets in the APB window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [`AVG_ADDR_W-1:0] {
		REG_CTRL  = 4'h0, // win_sel and enable
		REG_CLEAR = 4'h4, // write 1 to bit 0 to clear the history
		REG_LAST  = 4'h8, // most recent average, read only
		REG_COUNT = 4'hC  // averages since the last clear, read only
	} reg_addr_e;

endpackage

`default_nettype wire

// File: hdl/avg_apb_regs.sv
// APB register block for the moving-average filter with control, clear and status registers
`default_nettype none

`include "avg_config.svh"

module avg_apb_regs import avg_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire [`AVG_ADDR_W-1:0]  paddr,
	input  wire [31:0]             pwdata,
	input  wire                    avg_valid,
	input  wire sample_t           avg_data,
	output logic [31:0]            prdata,
	output logic                   pslverr,
	output win_sel_t               win_sel,
	output logic                   enable,
	output logic                   clear_hist
);

	localparam int PAD_W = 32 - `AVG_DATA_W;

	logic        access;
	logic        wr_en;
	logic        addr_err;
	reg_addr_e   addr;
	sample_t     last_avg;
	logic [15:0] avg_count;

	assign access = psel && penable; // APB access phase
	assign wr_en  = access && pwrite;
	assign addr   = reg_addr_e'(paddr);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control register and clear pulse
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_sel    <= '0;
			enable     <= 1'b0;
			clear_hist <= 1'b0;
		end else begin
			clear_hist <= wr_en && (addr == REG_CLEAR) && pwdata[0]; // high for one cycle only
			if (wr_en && (addr == REG_CTRL)) begin
				win_sel <= pwdata[2:0];
				enable  <= pwdata[3];
			end
		end
	end

	// status capture, a clear restarts both registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_avg  <= '0;
			avg_count <= '0;
		end else if (clear_hist) begin
			last_avg  <= '0;
			avg_count <= '0;
		end else if (avg_valid) begin
			last_avg  <= avg_data;
			avg_count <= avg_count + 16'd1; // wraps on overflow
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read mux and error decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		prdata   = '0;
		addr_err = 1'b0;
		case (addr)
			REG_CTRL: begin
				prdata = {28'd0, enable, win_sel};
			end
			REG_CLEAR: begin
				prdata = '0; // the clear is a pulse, nothing to read back
			end
			REG_LAST: begin
				prdata   = {{PAD_W{1'b0}}, last_avg};
				addr_err = pwrite;
			end
			REG_COUNT: begin
				prdata   = {16'd0, avg_count};
				addr_err = pwrite; // read-only register
			end
			default: begin
				addr_err = 1'b1;
			end
		endcase
	end

	assign pslverr = access && addr_err;

	// back-to-back APB transfers always have a setup cycle in between
	a_clear_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		clear_hist |=> !clear_hist);

	a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		!(psel && penable) |-> !pslverr);

endmodule

`default_nettype wire

// File: hdl/moving_avg.sv
// moving-average core with a 16-deep history, a selectable-window adder and output scaling
`default_nettype none

`include "avg_config.svh"

module moving_avg import avg_pkg::*; (
	input  wire           clk,
	input  wire           rst_n,
	input  wire win_sel_t win_sel,
	input  wire           enable,
	input  wire           clear_hist,
	input  wire           sample_valid,
	input  wire sample_t  sample_data,
	output logic          avg_valid,
	output sample_t       avg_data
);

	localparam int DEPTH = 1 << `AVG_MAX_LOG2;
	localparam int SUM_W = `AVG_DATA_W + `AVG_MAX_LOG2;

	sample_t                 hist [DEPTH];
	logic                    accept;
	win_sel_t                shift_sel;
	logic [`AVG_MAX_LOG2:0]  win_len;
	logic [SUM_W-1:0]        sum_d;
	logic [SUM_W-1:0]        sum_q;
	win_sel_t                shift_q;
	logic                    valid_q;

	assign accept = sample_valid && enable;

	// codes above the largest window act as the largest window
	always_comb begin
		if (win_sel > win_sel_t'(`AVG_MAX_LOG2))
			shift_sel = win_sel_t'(`AVG_MAX_LOG2);
		else
			shift_sel = win_sel;
	end

	assign win_len = (`AVG_MAX_LOG2 + 1)'(1) << shift_sel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// history line, hist[0] is the most recent accepted sample
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				hist[i] <= '0;
		end else if (clear_hist) begin
			for (int i = 0; i < DEPTH; i++)
				hist[i] <= '0;
		end else if (accept) begin
			hist[0] <= sample_data;
			for (int i = 1; i < DEPTH; i++)
				hist[i] <= hist[i-1];
		end
	end

	// current sample plus the previous window-minus-one samples
	always_comb begin
		sum_d = SUM_W'(sample_data);
		for (int i = 0; i < DEPTH; i++) begin
			if (i < int'(win_len) - 1)
				sum_d = sum_d + SUM_W'(hist[i]);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1 registers the sum, stage 2 scales it
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			avg_valid <= 1'b0;
		end else begin
			valid_q   <= accept && !clear_hist; // a clear drops the sample too
			avg_valid <= valid_q && !clear_hist;
		end
	end

	// the window travels with its sum so a later win_sel change does not matter
	always_ff @(posedge clk) begin
		sum_q    <= sum_d;
		shift_q  <= shift_sel;
		avg_data <= sample_t'(sum_q >> shift_q); // truncates, no rounding
	end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(accept && !clear_hist) ##1 !clear_hist |=> avg_valid);

	a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
		avg_valid |-> $past(accept && !clear_hist, 2));

	a_shift_range: assert property (@(posedge clk) disable iff (!rst_n)
		valid_q |-> (shift_q <= win_sel_t'(`AVG_MAX_LOG2)));

endmodule

`default_nettype wire

// File: hdl/avg_top.sv
// moving-average filter top level joining the APB register block to the filter core
`default_nettype none

`include "avg_config.svh"

module avg_top import avg_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    psel,
	input  wire                    penable,
	input  wire                    pwrite,
	input  wire [`AVG_ADDR_W-1:0]  paddr,
	input  wire [31:0]             pwdata,
	input  wire                    sample_valid,
	input  wire sample_t           sample_data,
	output logic [31:0]            prdata,
	output logic                   pslverr,
	output logic                   avg_valid,
	output sample_t                avg_data
);

	// control from the registers into the core
	win_sel_t win_sel;
	logic     enable;
	logic     clear_hist;

	avg_apb_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.avg_valid  (avg_valid), // status capture taps the output stream
		.avg_data   (avg_data),
		.prdata     (prdata),
		.pslverr    (pslverr),
		.win_sel    (win_sel),
		.enable     (enable),
		.clear_hist (clear_hist)
	);

	moving_avg u_filter (
		.clk          (clk),
		.rst_n        (rst_n),
		.win_sel      (win_sel),
		.enable       (enable),
		.clear_hist   (clear_hist),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.avg_valid    (avg_valid),
		.avg_data     (avg_data)
	);

endmodule

`default_nettype wire

// File: verif/avg_tb.sv
// testbench for the moving-average filter with APB and sample stimulus and a reference model
`default_nettype none

`include "avg_config.svh"

module avg_tb import avg_pkg::*; ();

	localparam int PERIOD      = 100;
	localparam int SAMPLES     = 48;
	localparam int HIST_DEPTH  = 1 << `AVG_MAX_LOG2;
	localparam int TEST_CYCLES = 16 + 60 + 10 * (SAMPLES + 16);
	localparam int MARGIN      = 200;

	logic                   clk;
	logic                   rst_n;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`AVG_ADDR_W-1:0] paddr;
	logic [31:0]            pwdata;
	logic                   sample_valid;
	sample_t                sample_data;
	logic [31:0]            prdata;
	logic                   pslverr;
	logic                   avg_valid;
	sample_t                avg_data;

	// the model's history queue keeps the newest sample at index 0
	sample_t     hist_q [$];
	sample_t     exp_q [$];
	sample_t     exp_head;
	sample_t     avg_e;
	sample_t     last_m;
	logic [15:0] count_m;
	int          exp_pending;
	logic [1:0]  acc_pipe; // samples accepted one and two edges ago
	win_sel_t    win_m;
	logic        en_m;
	int          clear_seq;
	int          clear_seen;
	logic [31:0] rd_exp;
	logic        rd_check;
	logic        err_exp;
	int          check_errors;
	int          flow_errors;

	avg_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.prdata       (prdata),
		.pslverr      (pslverr),
		.avg_valid    (avg_valid),
		.avg_data     (avg_data)
	);

	always #(PERIOD / 2) clk = ~clk;

	// sum of the window divided by its length where codes above 4 mean a window of 16
	function automatic sample_t model_avg(sample_t s);
		int          lg;
		int unsigned sum;
		lg  = (win_m > 3'd4) ? 4 : int'(win_m);
		sum = 32'(s);
		for (int i = 0; i < (1 << lg) - 1; i++)
			sum = sum + 32'(hist_q[i]);
		return sample_t'(sum >> lg);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model that runs on the edge at which the DUT accepts a sample
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		if (avg_valid && exp_q.size() > 0)
			void'(exp_q.pop_front()); // this average was checked at this edge
		if (!rst_n || clear_seq != clear_seen) begin
			hist_q.delete();
			for (int i = 0; i < HIST_DEPTH; i++)
				hist_q.push_back('0);
			exp_q.delete(); // a clear cancels the samples in flight
			acc_pipe   = '0;
			last_m     = '0;
			count_m    = '0;
			clear_seen = clear_seq;
		end else begin
			if (sample_valid && en_m) begin
				avg_e = model_avg(sample_data);
				exp_q.push_back(avg_e);
				hist_q.push_front(sample_data);
				void'(hist_q.pop_back());
				last_m  = avg_e;
				count_m = count_m + 16'd1;
			end
			acc_pipe = {acc_pipe[0], sample_valid && en_m};
		end
		exp_pending = exp_q.size();
		exp_head    = (exp_q.size() > 0) ? exp_q[0] : '0;
	end

	// an accepted sample shows up on avg_valid two edges later and nothing else does
	a_avg_timing: assert property (@(posedge clk) disable iff (!rst_n)
		avg_valid == acc_pipe[1])
		else begin
			check_errors++;
			$display("** Error at %0t: avg_valid = %0b, expected %0b",
				$time, $sampled(avg_valid), $sampled(acc_pipe[1]));
		end

	a_avg_value: assert property (@(posedge clk) disable iff (!rst_n)
		(avg_valid && exp_pending > 0) |-> (avg_data == exp_head))
		else begin
			check_errors++;
			$display("** Error at %0t: avg_data = 0x%04h, expected 0x%04h",
				$time, $sampled(avg_data), $sampled(exp_head));
		end

	a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && !pwrite && rd_check) |-> (prdata == rd_exp))
		else begin
			check_errors++;
			$display("** Error at %0t: prdata = 0x%08h, expected 0x%08h",
				$time, $sampled(prdata), $sampled(rd_exp));
		end

	a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable) |-> (pslverr == err_exp))
		else begin
			check_errors++;
			$display("** Error at %0t: pslverr = %0b, expected %0b",
				$time, $sampled(pslverr), $sampled(err_exp));
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB and stream tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apb_write(input reg_addr_e addr, input logic [31:0] data,
		input logic bad);
		@(negedge clk);
		psel    = 1'b1; // setup cycle
		pwrite  = 1'b1;
		penable = 1'b0;
		paddr   = addr;
		pwdata  = data;
		err_exp = bad;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		err_exp = 1'b0;
		if (!bad && addr == REG_CTRL) begin
			win_m = data[2:0];
			en_m  = data[3];
		end else if (!bad && addr == REG_CLEAR && data[0]) begin
			clear_seq++;
		end
	endtask

	task automatic apb_read(input reg_addr_e addr, input logic [31:0] exp);
		@(negedge clk);
		psel     = 1'b1;
		pwrite   = 1'b0;
		penable  = 1'b0;
		paddr    = addr;
		rd_exp   = exp;
		rd_check = 1'b1;
		err_exp  = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel     = 1'b0;
		penable  = 1'b0;
		rd_check = 1'b0;
	endtask

	task automatic send_samples(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			sample_valid = 1'b1; // one sample per cycle back to back
			sample_data  = sample_t'($urandom);
		end
		@(negedge clk);
		sample_valid = 1'b0;
	endtask

	// waits for every outstanding average to come out of the pipeline
	task automatic drain();
		int n;
		n = 0;
		while (exp_pending != 0 && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (exp_pending != 0) begin
			flow_errors++;
			$display("%0d averages still missing %0d cycles after the last sample",
				exp_pending, n);
		end
	endtask

	initial begin
		#((TEST_CYCLES + MARGIN) * PERIOD);
		$display("watchdog expired at %0t before the tests completed", $time);
		$display("Test failures found");
		$finish;
	end

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		sample_valid = 1'b0;
		sample_data  = '0;
		win_m        = '0;
		en_m         = 1'b0;
		clear_seq    = 0;
		clear_seen   = 0;
		rd_exp       = '0;
		rd_check     = 1'b0;
		err_exp      = 1'b0;
		check_errors = 0;
		flow_errors  = 0;
		void'($urandom(11));
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		// reset state and register access
		apb_read(REG_CTRL, 32'h0);
		apb_read(REG_LAST, 32'h0);
		apb_read(REG_COUNT, 32'h0);
		apb_write(REG_CTRL, 32'hFFFF_FFF5, 1'b0);
		apb_read(REG_CTRL, 32'h5);
		apb_write(REG_LAST, 32'h1234, 1'b1);
		apb_write(REG_COUNT, 32'h1, 1'b1);
		apb_read(REG_LAST, 32'h0);
		apb_read(REG_COUNT, 32'h0);
		apb_read(REG_CLEAR, 32'h0);

		// every window including codes 5 to 7
		for (int sel = 0; sel < 8; sel++) begin
			apb_write(REG_CTRL, 32'(8 + sel), 1'b0);
			apb_read(REG_CTRL, 32'(8 + sel));
			send_samples(SAMPLES);
			drain();
		end
		apb_read(REG_LAST, {16'd0, last_m});
		apb_read(REG_COUNT, {16'd0, count_m});

		// samples with enable low must not reach the history
		apb_write(REG_CTRL, 32'h3, 1'b0);
		send_samples(12);
		drain();
		apb_write(REG_CTRL, 32'hB, 1'b0);
		send_samples(SAMPLES);
		drain();

		apb_write(REG_CLEAR, 32'h1, 1'b0);
		apb_read(REG_COUNT, 32'h0);
		send_samples(SAMPLES / 2);
		drain();
		apb_read(REG_LAST, {16'd0, last_m});
		apb_read(REG_COUNT, {16'd0, count_m});

		repeat (4) @(negedge clk);
		$display("errors: %0d in checks, %0d in flow", check_errors, flow_errors);
		if (check_errors == 0 && flow_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hdl/avg_pkg.sv
hdl/avg_apb_regs.sv
hdl/moving_avg.sv
hdl/avg_top.sv
verif/avg_tb.sv

// File: Makefile
# Verilator build and run of the moving-average filter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = avg_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
